// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int XLEN = 32;
	localparam int REG_AW = 5;

	// major opcode field, inst[31:26]
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	// function field of special, inst[5:0]
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_lui
	} alu_op_e;

	typedef struct packed {
		logic [XLEN-1:0] inst;
		logic [XLEN-1:0] pc;
	} if_id_t;

	typedef struct packed {
		logic              valid;
		alu_op_e           alu_op;
		logic              use_imm;
		logic              reg_we;
		logic              mem_rd;
		logic              mem_wr;
		logic [REG_AW-1:0] dest;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [XLEN-1:0]   rs_val;
		logic [XLEN-1:0]   rt_val;
		logic [XLEN-1:0]   imm;
		logic [4:0]        shamt;
		logic [XLEN-1:0]   pc;
	} id_ex_t;

	typedef struct packed {
		logic              valid;
		logic              reg_we;
		logic              mem_rd;
		logic              mem_wr;
		logic [REG_AW-1:0] dest;
		logic [XLEN-1:0]   result;
		logic [XLEN-1:0]   store_data;
		logic [XLEN-1:0]   pc;
	} ex_mem_t;

	typedef struct packed {
		logic              valid;
		logic              reg_we;
		logic              mem_rd;
		logic [REG_AW-1:0] dest;
		logic [XLEN-1:0]   result;
		logic [XLEN-1:0]   load_data;
		logic [XLEN-1:0]   pc;
	} mem_wb_t;

	typedef struct packed {
		logic              we;
		logic [REG_AW-1:0] idx;
		logic [XLEN-1:0]   data;
	} rf_wr_t;

	typedef struct packed {
		logic            en;
		logic            we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} dmem_req_t;

	// writeback debug port
	typedef struct packed {
		logic              wen;
		logic [XLEN-1:0]   pc;
		logic [REG_AW-1:0] wnum;
		logic [XLEN-1:0]   wdata;
	} retire_t;

endpackage

`default_nettype wire

// File: verilog/fetch_stage.sv
`default_nettype none

module fetch_stage #(
	parameter logic [mips_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  wire                        clk,
	input  wire                        reset_i,
	input  wire                        stall_i,
	input  wire                        redirect_i,
	input  wire  [mips_pkg::XLEN-1:0]  target_i,
	input  wire  [mips_pkg::XLEN-1:0]  inst_data_i,
	output logic [mips_pkg::XLEN-1:0]  inst_addr_o,
	output mips_pkg::if_id_t           if_id_o
);

	logic [mips_pkg::XLEN-1:0] pc_q;
	mips_pkg::if_id_t          if_id_q;

	// stall wins over a redirect, the branch is still waiting in decode
	always_ff @(posedge clk)
	begin
		if (reset_i)
			pc_q <= RESET_PC;
		else if (!stall_i)
			pc_q <= redirect_i ? target_i : pc_q + 32'd4;
	end

	// no squash on redirect, this slot holds the delay-slot instruction
	always_ff @(posedge clk)
	begin
		if (reset_i)
			if_id_q <= '0;
		else if (!stall_i)
		begin
			if_id_q.inst <= inst_data_i;
			if_id_q.pc <= pc_q;
		end
	end

	assign inst_addr_o = pc_q;
	assign if_id_o = if_id_q;

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

module decode_stage (
	input  wire                        clk,
	input  wire                        reset_i,
	input  mips_pkg::if_id_t           if_id_i,
	input  mips_pkg::ex_mem_t          ex_mem_i,
	input  mips_pkg::rf_wr_t           rf_wr_i,
	output logic                       stall_o,
	output logic                       redirect_o,
	output logic [mips_pkg::XLEN-1:0]  target_o,
	output mips_pkg::id_ex_t           id_ex_o
);

	logic [mips_pkg::XLEN-1:0]   rf [32];
	logic [mips_pkg::REG_AW-1:0] rs_idx;
	logic [mips_pkg::REG_AW-1:0] rt_idx;
	logic [mips_pkg::REG_AW-1:0] rd_idx;
	logic [mips_pkg::XLEN-1:0]   rs_val;
	logic [mips_pkg::XLEN-1:0]   rt_val;
	mips_pkg::opcode_e           opcode;
	mips_pkg::funct_e            funct;
	logic                        zero_ext;
	logic                        is_branch;
	logic                        load_use;
	logic                        ex_hit;
	logic                        mem_hit;
	mips_pkg::id_ex_t            id_ex_d;
	mips_pkg::id_ex_t            id_ex_q;

	assign opcode = mips_pkg::opcode_e'(if_id_i.inst[31:26]);
	assign funct = mips_pkg::funct_e'(if_id_i.inst[5:0]);
	assign rs_idx = if_id_i.inst[25:21];
	assign rt_idx = if_id_i.inst[20:16];
	assign rd_idx = if_id_i.inst[15:11];
	assign zero_ext = (opcode == mips_pkg::op_andi) || (opcode == mips_pkg::op_ori) ||
		(opcode == mips_pkg::op_xori);

	// register file, r0 reads zero and writeback is visible in the same cycle
	function automatic logic [mips_pkg::XLEN-1:0] rf_read(
		input logic [mips_pkg::REG_AW-1:0] idx
	);
		if (idx == '0)
			return '0;
		else if (rf_wr_i.we && rf_wr_i.idx == idx)
			return rf_wr_i.data;
		else
			return rf[idx];
	endfunction

	always_comb
	begin
		rs_val = rf_read(rs_idx);
		rt_val = rf_read(rt_idx);
	end

	always_ff @(posedge clk)
	begin
		if (rf_wr_i.we && rf_wr_i.idx != '0)
			rf[rf_wr_i.idx] <= rf_wr_i.data;
	end

	// defaults describe an immediate-form alu op writing rt
	always_comb
	begin
		id_ex_d = '0;
		id_ex_d.valid = 1'b1;
		id_ex_d.rs = rs_idx;
		id_ex_d.rt = rt_idx;
		id_ex_d.rs_val = rs_val;
		id_ex_d.rt_val = rt_val;
		id_ex_d.imm = zero_ext ? {16'h0, if_id_i.inst[15:0]} :
			{{16{if_id_i.inst[15]}}, if_id_i.inst[15:0]};
		id_ex_d.shamt = if_id_i.inst[10:6];
		id_ex_d.pc = if_id_i.pc;
		id_ex_d.dest = rt_idx;
		id_ex_d.use_imm = 1'b1;
		id_ex_d.reg_we = 1'b1;
		id_ex_d.alu_op = mips_pkg::alu_add;
		is_branch = 1'b0;
		case (opcode)
			mips_pkg::op_special:
			begin
				id_ex_d.dest = rd_idx;
				id_ex_d.use_imm = 1'b0;
				case (funct)
					mips_pkg::fn_sll: id_ex_d.alu_op = mips_pkg::alu_sll;
					mips_pkg::fn_srl: id_ex_d.alu_op = mips_pkg::alu_srl;
					mips_pkg::fn_addu: id_ex_d.alu_op = mips_pkg::alu_add;
					mips_pkg::fn_subu: id_ex_d.alu_op = mips_pkg::alu_sub;
					mips_pkg::fn_and: id_ex_d.alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or: id_ex_d.alu_op = mips_pkg::alu_or;
					mips_pkg::fn_xor: id_ex_d.alu_op = mips_pkg::alu_xor;
					mips_pkg::fn_nor: id_ex_d.alu_op = mips_pkg::alu_nor;
					mips_pkg::fn_slt: id_ex_d.alu_op = mips_pkg::alu_slt;
					mips_pkg::fn_sltu: id_ex_d.alu_op = mips_pkg::alu_sltu;
					default: id_ex_d.reg_we = 1'b0;
				endcase
			end
			mips_pkg::op_addiu: id_ex_d.alu_op = mips_pkg::alu_add;
			mips_pkg::op_slti: id_ex_d.alu_op = mips_pkg::alu_slt;
			mips_pkg::op_andi: id_ex_d.alu_op = mips_pkg::alu_and;
			mips_pkg::op_ori: id_ex_d.alu_op = mips_pkg::alu_or;
			mips_pkg::op_xori: id_ex_d.alu_op = mips_pkg::alu_xor;
			mips_pkg::op_lui: id_ex_d.alu_op = mips_pkg::alu_lui;
			mips_pkg::op_lw: id_ex_d.mem_rd = 1'b1;
			mips_pkg::op_sw:
			begin
				id_ex_d.mem_wr = 1'b1;
				id_ex_d.reg_we = 1'b0;
			end
			mips_pkg::op_beq, mips_pkg::op_bne:
			begin
				is_branch = 1'b1;
				id_ex_d.reg_we = 1'b0;
			end
			default: id_ex_d.reg_we = 1'b0;
		endcase
	end

	// branch resolves here, bne inverts the equality
	assign redirect_o = is_branch & ((rs_val == rt_val) ^ (opcode == mips_pkg::op_bne));
	assign target_o = if_id_i.pc + 32'd4 + {{14{if_id_i.inst[15]}}, if_id_i.inst[15:0], 2'b00};

	// hazards against execute (own register) and memory
	assign load_use = id_ex_q.valid && id_ex_q.mem_rd && id_ex_q.dest != '0 &&
		(id_ex_q.dest == rs_idx || id_ex_q.dest == rt_idx);
	assign ex_hit = id_ex_q.valid && id_ex_q.reg_we && id_ex_q.dest != '0 &&
		(id_ex_q.dest == rs_idx || id_ex_q.dest == rt_idx);
	assign mem_hit = ex_mem_i.valid && ex_mem_i.reg_we && ex_mem_i.dest != '0 &&
		(ex_mem_i.dest == rs_idx || ex_mem_i.dest == rt_idx);
	assign stall_o = load_use || (is_branch && (ex_hit || mem_hit));

	// bubble into execute on a stall
	always_ff @(posedge clk)
	begin
		if (reset_i || stall_o)
			id_ex_q <= '0;
		else
			id_ex_q <= id_ex_d;
	end

	assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`default_nettype none

module execute_stage (
	input  wire                 clk,
	input  wire                 reset_i,
	input  mips_pkg::id_ex_t    id_ex_i,
	input  mips_pkg::rf_wr_t    rf_wr_i,
	output mips_pkg::ex_mem_t   ex_mem_o
);

	logic [mips_pkg::XLEN-1:0] rs_fwd;
	logic [mips_pkg::XLEN-1:0] rt_fwd;
	logic [mips_pkg::XLEN-1:0] op_b;
	logic [mips_pkg::XLEN-1:0] alu_res;
	mips_pkg::ex_mem_t         ex_mem_q;

	// memory-stage alu result first, then writeback, then the decode value
	// loads in memory are skipped, the load-use stall covers them
	function automatic logic [mips_pkg::XLEN-1:0] fwd_sel(
		input logic [mips_pkg::REG_AW-1:0] idx,
		input logic [mips_pkg::XLEN-1:0]   dec_val
	);
		if (ex_mem_q.valid && ex_mem_q.reg_we && !ex_mem_q.mem_rd &&
			ex_mem_q.dest != '0 && ex_mem_q.dest == idx)
			return ex_mem_q.result;
		else if (rf_wr_i.we && rf_wr_i.idx != '0 && rf_wr_i.idx == idx)
			return rf_wr_i.data;
		else
			return dec_val;
	endfunction

	always_comb
	begin
		rs_fwd = fwd_sel(id_ex_i.rs, id_ex_i.rs_val);
		rt_fwd = fwd_sel(id_ex_i.rt, id_ex_i.rt_val);
	end

	assign op_b = id_ex_i.use_imm ? id_ex_i.imm : rt_fwd;

	// shifts take rt through op_b, lw/sw address is rs plus imm via add
	always_comb
	begin
		case (id_ex_i.alu_op)
			mips_pkg::alu_add: alu_res = rs_fwd + op_b;
			mips_pkg::alu_sub: alu_res = rs_fwd - op_b;
			mips_pkg::alu_and: alu_res = rs_fwd & op_b;
			mips_pkg::alu_or: alu_res = rs_fwd | op_b;
			mips_pkg::alu_xor: alu_res = rs_fwd ^ op_b;
			mips_pkg::alu_nor: alu_res = ~(rs_fwd | op_b);
			mips_pkg::alu_slt: alu_res = {31'b0, $signed(rs_fwd) < $signed(op_b)};
			mips_pkg::alu_sltu: alu_res = {31'b0, rs_fwd < op_b};
			mips_pkg::alu_sll: alu_res = op_b << id_ex_i.shamt;
			mips_pkg::alu_srl: alu_res = op_b >> id_ex_i.shamt;
			mips_pkg::alu_lui: alu_res = {op_b[15:0], 16'h0};
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			ex_mem_q <= '0;
		else
		begin
			ex_mem_q.valid <= id_ex_i.valid;
			ex_mem_q.reg_we <= id_ex_i.valid & id_ex_i.reg_we;
			ex_mem_q.mem_rd <= id_ex_i.valid & id_ex_i.mem_rd;
			ex_mem_q.mem_wr <= id_ex_i.valid & id_ex_i.mem_wr;
			ex_mem_q.dest <= id_ex_i.dest;
			ex_mem_q.result <= alu_res;
			ex_mem_q.store_data <= rt_fwd;
			ex_mem_q.pc <= id_ex_i.pc;
		end
	end

	assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

// File: verilog/mem_wb_stage.sv
`default_nettype none

module mem_wb_stage (
	input  wire                        clk,
	input  wire                        reset_i,
	input  mips_pkg::ex_mem_t          ex_mem_i,
	input  wire  [mips_pkg::XLEN-1:0]  dmem_rdata_i,
	output mips_pkg::dmem_req_t        dmem_req_o,
	output mips_pkg::rf_wr_t           rf_wr_o,
	output mips_pkg::retire_t          retire_o
);

	mips_pkg::mem_wb_t         mem_wb_q;
	logic [mips_pkg::XLEN-1:0] wb_data;

	// memory answers in the same cycle
	always_comb
	begin
		dmem_req_o.en = ex_mem_i.valid & (ex_mem_i.mem_rd | ex_mem_i.mem_wr);
		dmem_req_o.we = ex_mem_i.valid & ex_mem_i.mem_wr;
		dmem_req_o.addr = ex_mem_i.result;
		dmem_req_o.wdata = ex_mem_i.store_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			mem_wb_q <= '0;
		else
		begin
			mem_wb_q.valid <= ex_mem_i.valid;
			mem_wb_q.reg_we <= ex_mem_i.reg_we;
			mem_wb_q.mem_rd <= ex_mem_i.mem_rd;
			mem_wb_q.dest <= ex_mem_i.dest;
			mem_wb_q.result <= ex_mem_i.result;
			mem_wb_q.load_data <= dmem_rdata_i;
			mem_wb_q.pc <= ex_mem_i.pc;
		end
	end

	assign wb_data = mem_wb_q.mem_rd ? mem_wb_q.load_data : mem_wb_q.result;

	always_comb
	begin
		rf_wr_o.we = mem_wb_q.valid & mem_wb_q.reg_we;
		rf_wr_o.idx = mem_wb_q.dest;
		rf_wr_o.data = wb_data;
		// r0 writes never show up on the debug port
		retire_o.wen = mem_wb_q.valid & mem_wb_q.reg_we & (mem_wb_q.dest != '0);
		retire_o.pc = mem_wb_q.pc;
		retire_o.wnum = mem_wb_q.dest;
		retire_o.wdata = wb_data;
	end

endmodule

`default_nettype wire

// File: verilog/mips_core.sv
`default_nettype none

module mips_core #(
	parameter logic [mips_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  wire                         clk,
	input  wire                         reset_i,
	output logic [mips_pkg::XLEN-1:0]   inst_addr_o,
	input  wire  [mips_pkg::XLEN-1:0]   inst_data_i,
	output mips_pkg::dmem_req_t         dmem_req_o,
	input  wire  [mips_pkg::XLEN-1:0]   dmem_rdata_i,
	output mips_pkg::retire_t           retire_o
);

	mips_pkg::if_id_t           if_id;
	mips_pkg::id_ex_t           id_ex;
	mips_pkg::ex_mem_t          ex_mem;
	mips_pkg::rf_wr_t           rf_wr;
	logic                       stall;
	logic                       redirect;
	logic [mips_pkg::XLEN-1:0]  target;

	// input side
	fetch_stage #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk        (clk),
		.reset_i    (reset_i),
		.stall_i    (stall),
		.redirect_i (redirect),
		.target_i   (target),
		.inst_data_i(inst_data_i),
		.inst_addr_o(inst_addr_o),
		.if_id_o    (if_id)
	);

	// processing
	decode_stage u_decode (
		.clk       (clk),
		.reset_i   (reset_i),
		.if_id_i   (if_id),
		.ex_mem_i  (ex_mem),
		.rf_wr_i   (rf_wr),
		.stall_o   (stall),
		.redirect_o(redirect),
		.target_o  (target),
		.id_ex_o   (id_ex)
	);

	execute_stage u_execute (
		.clk     (clk),
		.reset_i (reset_i),
		.id_ex_i (id_ex),
		.rf_wr_i (rf_wr),
		.ex_mem_o(ex_mem)
	);

	// output side
	mem_wb_stage u_mem_wb (
		.clk         (clk),
		.reset_i     (reset_i),
		.ex_mem_i    (ex_mem),
		.dmem_rdata_i(dmem_rdata_i),
		.dmem_req_o  (dmem_req_o),
		.rf_wr_o     (rf_wr),
		.retire_o    (retire_o)
	);

endmodule

`default_nettype wire

// File: dv/mips_ref_model.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// one expected nonzero register write
typedef struct packed {
	logic [31:0] pc;
	logic [4:0]  wnum;
	logic [31:0] wdata;
} ret_ev_t;

// one expected store
typedef struct packed {
	logic [31:0] addr;
	logic [31:0] data;
} st_ev_t;

ret_ev_t exp_ret [$];
st_ev_t  exp_st [$];

// data memory power-up contents, every address bit matters
function automatic logic [31:0] dmem_fill(input int idx);
	return (32'(idx) * 32'h9e37_79b9) ^ 32'h1357_2468;
endfunction

// architectural run of imem from pc 0, stops at the closing self-branch
function automatic void run_reference();
	logic [31:0] regs [32];
	logic [31:0] mem [DMEM_WORDS];
	logic [31:0] pc;
	logic [31:0] npc;
	logic [31:0] nnpc;
	logic [31:0] inst;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sext;
	logic [31:0] addr;
	logic [31:0] res;
	logic [4:0]  dest;
	logic        wr;
	ret_ev_t     rev;
	st_ev_t      sev;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	for (int i = 0; i < DMEM_WORDS; i++)
		mem[i] = dmem_fill(i);
	pc = '0;
	npc = 32'd4;
	for (int step = 0; step < 4000; step++)
	begin
		inst = imem[pc[10:2]];
		a = regs[inst[25:21]];
		b = regs[inst[20:16]];
		sext = {{16{inst[15]}}, inst[15:0]};
		addr = a + sext;
		nnpc = npc + 32'd4;
		dest = inst[20:16];
		wr = 1'b1;
		res = '0;
		case (inst[31:26])
			mips_pkg::op_special:
			begin
				dest = inst[15:11];
				case (inst[5:0])
					mips_pkg::fn_sll: res = b << inst[10:6];
					mips_pkg::fn_srl: res = b >> inst[10:6];
					mips_pkg::fn_addu: res = a + b;
					mips_pkg::fn_subu: res = a - b;
					mips_pkg::fn_and: res = a & b;
					mips_pkg::fn_or: res = a | b;
					mips_pkg::fn_xor: res = a ^ b;
					mips_pkg::fn_nor: res = ~(a | b);
					mips_pkg::fn_slt: res = {31'h0, $signed(a) < $signed(b)};
					mips_pkg::fn_sltu: res = {31'h0, a < b};
					default: wr = 1'b0;
				endcase
			end
			mips_pkg::op_addiu: res = addr;
			mips_pkg::op_slti: res = {31'h0, $signed(a) < $signed(sext)};
			mips_pkg::op_andi: res = a & {16'h0, inst[15:0]};
			mips_pkg::op_ori: res = a | {16'h0, inst[15:0]};
			mips_pkg::op_xori: res = a ^ {16'h0, inst[15:0]};
			mips_pkg::op_lui: res = {inst[15:0], 16'h0};
			mips_pkg::op_lw: res = mem[addr[7:2]];
			mips_pkg::op_sw:
			begin
				wr = 1'b0;
				mem[addr[7:2]] = b;
				sev.addr = addr;
				sev.data = b;
				exp_st.push_back(sev);
			end
			mips_pkg::op_beq, mips_pkg::op_bne:
			begin
				wr = 1'b0;
				// the slot at npc runs either way, the target follows it
				if ((a == b) == (inst[31:26] == mips_pkg::op_beq))
				begin
					nnpc = pc + 32'd4 + (sext << 2);
					if (nnpc == pc)
						return;
				end
			end
			default: wr = 1'b0;
		endcase
		if (wr && dest != '0)
		begin
			regs[dest] = res;
			rev.pc = pc;
			rev.wnum = dest;
			rev.wdata = res;
			exp_ret.push_back(rev);
		end
		pc = npc;
		npc = nnpc;
	end
endfunction

`endif

// File: dv/mips_tb.sv
`default_nettype none

module mips_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IMEM_WORDS = 512;
	localparam int DMEM_WORDS = 64;

	logic                      clk = 1'b0;
	logic                      reset_i = 1'b1;
	logic [mips_pkg::XLEN-1:0] inst_addr;
	logic [mips_pkg::XLEN-1:0] inst_data = '0;
	mips_pkg::dmem_req_t       dmem_req;
	logic [mips_pkg::XLEN-1:0] dmem_rdata = '0;
	mips_pkg::retire_t         retire;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] prog [$];

	`include "mips_ref_model.svh"

	ret_ev_t ret_next;
	st_ev_t  st_next;

	mips_core #(
		.RESET_PC(32'h0)
	) DUT (
		.clk         (clk),
		.reset_i     (reset_i),
		.inst_addr_o (inst_addr),
		.inst_data_i (inst_data),
		.dmem_req_o  (dmem_req),
		.dmem_rdata_i(dmem_rdata),
		.retire_o    (retire)
	);

	always #10 clk = ~clk;

	// both memories answer 1 ns after each rising edge
	// load data only while a read is requested
	always @(posedge clk)
	begin
		#1;
		inst_data = imem[inst_addr[10:2]];
		if (dmem_req.en && !dmem_req.we)
			dmem_rdata = dmem[dmem_req.addr[7:2]];
		else
			dmem_rdata = 32'hdead_beef;
	end

	// data memory refills during reset
	always @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= dmem_fill(i);
		end
		else if (dmem_req.en && dmem_req.we)
			dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	// retirement compare on the falling edge
	always @(negedge clk)
	begin
		if (!reset_i && retire.wen)
		begin
			if (exp_ret.size() == 0)
				fail_run("a register write retired that the program never makes");
			else
			begin
				ret_next = exp_ret.pop_front();
				check_value("retire_o.pc", retire.pc, ret_next.pc);
				check_value("retire_o.wnum", 32'(retire.wnum), 32'(ret_next.wnum));
				check_value("retire_o.wdata", retire.wdata, ret_next.wdata);
			end
		end
	end

	// store compare
	always @(negedge clk)
	begin
		if (!reset_i && dmem_req.en && dmem_req.we)
		begin
			if (exp_st.size() == 0)
				fail_run("a store request appeared that the program never makes");
			else
			begin
				st_next = exp_st.pop_front();
				check_value("dmem_req_o.addr", dmem_req.addr, st_next.addr);
				check_value("dmem_req_o.wdata", dmem_req.wdata, st_next.data);
			end
		end
	end

	function automatic void imm_inst(input logic [5:0] op, input int rt, input int rs,
		input int imm);
		prog.push_back({op, 5'(rs), 5'(rt), 16'(imm)});
	endfunction

	function automatic void reg_inst(input logic [5:0] fn, input int rd, input int rs,
		input int rt, input int sh);
		prog.push_back({mips_pkg::op_special, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn});
	endfunction

	function automatic void alu_program();
		imm_inst(mips_pkg::op_addiu, 1, 0, 32'h7ff0);
		imm_inst(mips_pkg::op_addiu, 2, 0, -5);
		imm_inst(mips_pkg::op_lui, 3, 0, 32'h8001);
		imm_inst(mips_pkg::op_ori, 3, 3, 32'h00ff);
		imm_inst(mips_pkg::op_andi, 4, 2, 32'h0ff0);
		imm_inst(mips_pkg::op_xori, 5, 1, 32'hffff);
		imm_inst(mips_pkg::op_slti, 6, 2, 3);
		imm_inst(mips_pkg::op_slti, 7, 1, -1);
		reg_inst(mips_pkg::fn_addu, 8, 1, 2, 0);
		reg_inst(mips_pkg::fn_subu, 9, 1, 2, 0);
		reg_inst(mips_pkg::fn_and, 10, 3, 2, 0);
		reg_inst(mips_pkg::fn_or, 11, 1, 3, 0);
		reg_inst(mips_pkg::fn_xor, 12, 2, 3, 0);
		reg_inst(mips_pkg::fn_nor, 13, 1, 2, 0);
		reg_inst(mips_pkg::fn_slt, 14, 3, 1, 0);
		reg_inst(mips_pkg::fn_sltu, 15, 3, 1, 0);
		reg_inst(mips_pkg::fn_sll, 16, 0, 2, 4);
		reg_inst(mips_pkg::fn_srl, 17, 0, 2, 28);
	endfunction

	// each one leans on the one or two before it
	function automatic void forward_program();
		imm_inst(mips_pkg::op_addiu, 1, 0, 3);
		reg_inst(mips_pkg::fn_addu, 2, 1, 1, 0);
		reg_inst(mips_pkg::fn_addu, 3, 2, 1, 0);
		reg_inst(mips_pkg::fn_subu, 4, 3, 2, 0);
		reg_inst(mips_pkg::fn_addu, 4, 4, 4, 0);
		reg_inst(mips_pkg::fn_xor, 5, 4, 1, 0);
		reg_inst(mips_pkg::fn_sll, 6, 0, 5, 3);
		imm_inst(mips_pkg::op_addiu, 6, 6, 1);
	endfunction

	function automatic void memory_program();
		imm_inst(mips_pkg::op_addiu, 1, 0, 32'h20);
		imm_inst(mips_pkg::op_addiu, 2, 0, 32'h5a5);
		imm_inst(mips_pkg::op_sw, 2, 1, 0);
		imm_inst(mips_pkg::op_sw, 1, 1, 4);
		imm_inst(mips_pkg::op_lw, 3, 1, 0);
		reg_inst(mips_pkg::fn_addu, 4, 3, 3, 0);
		imm_inst(mips_pkg::op_lw, 5, 1, 4);
		imm_inst(mips_pkg::op_sw, 5, 1, 8);
		imm_inst(mips_pkg::op_lw, 6, 5, 8);
		imm_inst(mips_pkg::op_addiu, 6, 6, 1);
		imm_inst(mips_pkg::op_lw, 7, 0, 12);
		reg_inst(mips_pkg::fn_or, 8, 7, 4, 0);
	endfunction

	// word index in the comment where the offset matters
	function automatic void branch_program();
		imm_inst(mips_pkg::op_addiu, 1, 0, 5);
		imm_inst(mips_pkg::op_addiu, 2, 0, 5);
		imm_inst(mips_pkg::op_addiu, 13, 0, 0);
		imm_inst(mips_pkg::op_beq, 2, 1, 2);
		imm_inst(mips_pkg::op_addiu, 3, 0, 1);
		imm_inst(mips_pkg::op_addiu, 4, 0, 99);
		imm_inst(mips_pkg::op_addiu, 5, 0, 7);
		imm_inst(mips_pkg::op_bne, 2, 1, 2);
		imm_inst(mips_pkg::op_addiu, 6, 0, 2);
		imm_inst(mips_pkg::op_addiu, 7, 0, 3);
		imm_inst(mips_pkg::op_addiu, 8, 0, 4);
		// word 11 branches on r8 still in execute
		imm_inst(mips_pkg::op_bne, 1, 8, 2);
		reg_inst(mips_pkg::fn_addu, 9, 8, 1, 0);
		imm_inst(mips_pkg::op_addiu, 10, 0, 1);
		imm_inst(mips_pkg::op_beq, 0, 8, 2);
		imm_inst(mips_pkg::op_addiu, 11, 0, 11);
		imm_inst(mips_pkg::op_addiu, 12, 0, 3);
		// words 17 to 19 count r12 down while the slot bumps r13
		imm_inst(mips_pkg::op_addiu, 12, 12, -1);
		imm_inst(mips_pkg::op_bne, 0, 12, -2);
		imm_inst(mips_pkg::op_addiu, 13, 13, 1);
		reg_inst(mips_pkg::fn_addu, 14, 13, 12, 0);
	endfunction

	function automatic void zero_reg_program();
		imm_inst(mips_pkg::op_addiu, 0, 0, 5);
		reg_inst(mips_pkg::fn_addu, 1, 0, 0, 0);
		imm_inst(mips_pkg::op_lui, 0, 0, 32'hffff);
		imm_inst(mips_pkg::op_ori, 2, 0, 32'h12);
		imm_inst(mips_pkg::op_lw, 0, 0, 0);
		reg_inst(mips_pkg::fn_addu, 3, 0, 0, 0);
		imm_inst(mips_pkg::op_sw, 0, 0, 16);
		imm_inst(mips_pkg::op_addiu, 4, 0, -1);
	endfunction

	function automatic void random_program();
		logic [5:0] r_ops [8];
		logic [5:0] i_ops [6];
		int kind;
		int pick;
		int rd;
		int rs;
		int rt;
		r_ops = '{mips_pkg::fn_addu, mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
			mips_pkg::fn_xor, mips_pkg::fn_nor, mips_pkg::fn_slt, mips_pkg::fn_sltu};
		i_ops = '{mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_andi,
			mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui};
		// the register file keeps old values across runs so r1..r7 get known ones first
		for (int r = 1; r < 8; r++)
			imm_inst(mips_pkg::op_addiu, r, 0, int'($urandom));
		for (int n = 0; n < 200; n++)
		begin
			kind = int'($urandom % 32'd5);
			pick = int'($urandom % 32'd8);
			rd = int'($urandom % 32'd8);
			rs = int'($urandom % 32'd8);
			rt = int'($urandom % 32'd8);
			case (kind)
				0: reg_inst(r_ops[pick], rd, rs, rt, 0);
				1: imm_inst(i_ops[pick % 6], rt, rs, int'($urandom));
				2: reg_inst(pick[0] ? mips_pkg::fn_sll : mips_pkg::fn_srl, rd, 0, rt,
					int'($urandom % 32'd32));
				3: imm_inst(mips_pkg::op_lw, rt, 0, 4 * int'($urandom % 32'd16));
				default: imm_inst(mips_pkg::op_sw, rt, 0, 4 * int'($urandom % 32'd16));
			endcase
		end
	endfunction

	// reset, load, predict, then run until every expected event has been seen
	task automatic run_program(input string name);
		int cycles;
		imm_inst(mips_pkg::op_beq, 0, 0, -1);
		prog.push_back(32'h0);
		reset_i = 1'b1;
		@(posedge clk);
		#1;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
		exp_ret.delete();
		exp_st.delete();
		run_reference();
		repeat (3) @(posedge clk);
		#1;
		check_value("inst_addr_o", inst_addr, 32'h0);
		check_value("retire_o.wen", 32'(retire.wen), 32'h0);
		check_value("dmem_req_o.en", 32'(dmem_req.en), 32'h0);
		check_value("dmem_req_o.we", 32'(dmem_req.we), 32'h0);
		reset_i = 1'b0;
		cycles = 0;
		while ((exp_ret.size() != 0 || exp_st.size() != 0) && cycles < 3000)
		begin
			@(negedge clk);
			cycles++;
		end
		if (exp_ret.size() != 0 || exp_st.size() != 0)
			fail_run($sformatf("timeout: program %s left writes or stores outstanding", name));
		// a few more cycles to catch anything extra
		repeat (10) @(posedge clk);
		#1;
		prog.delete();
	endtask

	initial
	begin
		void'($urandom(40958));
		alu_program();
		run_program("alu");
		forward_program();
		run_program("forward");
		memory_program();
		run_program("memory");
		branch_program();
		run_program("branch");
		random_program();
		run_program("random");
		zero_reg_program();
		run_program("zero_reg");
		if (exp_ret.size() == 0 && exp_st.size() == 0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
			fail_run("expected events were left over at the end of the run");
	end

endmodule

`default_nettype wire

// File: mips_lite.f
+incdir+dv
verilog/mips_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/mips_core.sv
dv/mips_tb.sv

// File: Makefile
# Verilator build and run of the mips_lite testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run mips_tb"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 --top-module mips_tb -Mdir obj_dir -f mips_lite.f
	./obj_dir/Vmips_tb | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
